/* verilog.f */
+incdir+.
dq_pkg.sv
dq_port_if.sv
dq_bus_arbiter.sv
dq_irq_ctrl.sv
dq_regfile.sv
dq_regs_top.sv
dq_regs_checker.sv
tb_dq_regs.sv

/* tb_dq_regs.sv */
//**************************************************
// testbench of the register block
// applies a table of host and firmware bus accesses,
// interrupt steps and one contended read, checks the
// read data and latencies, prints an error summary
//**************************************************
`timescale 1ns/1ps
`include "dq_defs.svh"
`default_nettype none

module tb_dq_regs;

   localparam int K_EXT  = 0;                  // host bus access
   localparam int K_INT  = 1;                  // firmware bus access
   localparam int K_IRQ  = 2;                  // irq level check
   localparam int K_IACK = 3;                  // one cycle iack pulse
   localparam int K_DUAL = 4;                  // both buses read at once
   localparam logic [63:0] ROM = `DQ_SA_ROM;

   typedef struct {
      int          kind;
      logic        we;
      logic [2:0]  adr;
      logic [1:0]  sel;
      logic [15:0] wdat;
      logic [15:0] exp;                        // read data or irq level
      bit          chk;                        // 0 = no check
      logic [2:0]  adr2;                       // firmware side of K_DUAL
      logic [15:0] exp2;
   } op_t;

   logic                 lwb_clk_i;
   logic                 comb_res;
   logic [`DQ_ADR_W-1:0] lwb_adr_i;
   logic [`DQ_DAT_W-1:0] lwb_dat_i;
   logic                 lwb_cyc_i;
   logic                 lwb_we_i;
   logic [`DQ_SEL_W-1:0] lwb_sel_i;
   logic                 lrg_stb_i;
   logic [`DQ_DAT_W-1:0] lwb_dat_o;
   logic                 lwb_ack_o;
   logic [`DQ_ADR_W-1:0] ewb_adr_i;
   logic [`DQ_DAT_W-1:0] ewb_dat_i;
   logic                 ewb_cyc_i;
   logic                 ewb_we_i;
   logic [`DQ_SEL_W-1:0] ewb_sel_i;
   logic                 erg_stb_i;
   logic [`DQ_DAT_W-1:0] ewb_dat_o;
   logic                 ewb_ack_o;
   logic                 s3_i;
   logic                 s4_i;
   logic                 carrier_i;
   logic                 link_i;
   logic                 iack_i;
   logic                 irq_o;

   op_t ops[$];                                // operation table
   int  n_chk = 0;
   int  n_err = 0;

   dq_regs_top i_dut (.*);

   initial begin
      lwb_clk_i = 1'b0;
      forever #50 lwb_clk_i = ~lwb_clk_i;      // 100 ns period
   end

   //**************************************************
   // helpers
   function automatic void add_op(int kind, logic we, logic [2:0] adr, logic [1:0] sel,
                                  logic [15:0] wdat, logic [15:0] exp, bit chk);
      op_t o;
      o = '{kind, we, adr, sel, wdat, exp, chk, 3'd0, 16'h0};
      ops.push_back(o);
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      n_chk++;
      assert (act === exp) else begin
         $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
         n_err++;
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge lwb_clk_i);
         @(negedge lwb_clk_i);
      end
   endtask

   // one access on one bus, entered and left on a falling edge
   task automatic bus_op(input op_t o, output logic [15:0] rdat, output int edges);
      bit ext;
      bit got;
      ext   = (o.kind == K_EXT);
      edges = 0;
      got   = 1'b0;
      if (ext) begin
         ewb_adr_i = o.adr;
         ewb_sel_i = o.sel;
         ewb_dat_i = o.wdat;
         ewb_we_i  = o.we;
         ewb_cyc_i = 1'b1;
         erg_stb_i = 1'b1;
      end else begin
         lwb_adr_i = o.adr;
         lwb_sel_i = o.sel;
         lwb_dat_i = o.wdat;
         lwb_we_i  = o.we;
         lwb_cyc_i = 1'b1;
         lrg_stb_i = 1'b1;
      end
      for (int cnt = 0; cnt < 20 && !got; cnt++) begin   // ack timeout
         @(posedge lwb_clk_i);
         edges++;
         @(negedge lwb_clk_i);
         got = ext ? ewb_ack_o : lwb_ack_o;
      end
      rdat = ext ? ewb_dat_o : lwb_dat_o;
      if (!got) begin
         $display("no ack from the %s bus within 20 cycles", ext ? "host" : "firmware");
         n_err++;
      end
      ewb_cyc_i = 1'b0;
      erg_stb_i = 1'b0;
      lwb_cyc_i = 1'b0;
      lrg_stb_i = 1'b0;
   endtask

   task automatic check_irq(input logic exp);
      logic seen;
      seen = 1'b0;
      for (int cnt = 0; cnt < 4; cnt++) begin   // irq window of 4 cycles
         @(posedge lwb_clk_i);
         @(negedge lwb_clk_i);
         seen = seen | irq_o;
      end
      check_val("irq_o", exp, seen);
   endtask

   // both buses start a read on the same falling edge
   task automatic dual_read(input op_t o);
      logic [15:0] e_dat;
      logic [15:0] i_dat;
      bit          e_done;
      bit          i_done;
      bit          ext_first;
      e_done    = 1'b0;
      i_done    = 1'b0;
      ext_first = 1'b0;
      ewb_adr_i = o.adr;
      ewb_we_i  = 1'b0;
      ewb_sel_i = 2'b11;
      lwb_adr_i = o.adr2;
      lwb_we_i  = 1'b0;
      lwb_sel_i = 2'b11;
      ewb_cyc_i = 1'b1;
      erg_stb_i = 1'b1;
      lwb_cyc_i = 1'b1;
      lrg_stb_i = 1'b1;
      for (int cnt = 0; cnt < 20 && !(e_done && i_done); cnt++) begin
         @(posedge lwb_clk_i);
         @(negedge lwb_clk_i);
         if (!i_done && lwb_ack_o) begin
            i_dat     = lwb_dat_o;
            i_done    = 1'b1;
            ext_first = e_done;               // host must be done already
            lwb_cyc_i = 1'b0;
            lrg_stb_i = 1'b0;
         end
         if (!e_done && ewb_ack_o) begin
            e_dat     = ewb_dat_o;
            e_done    = 1'b1;
            ewb_cyc_i = 1'b0;
            erg_stb_i = 1'b0;
         end
      end
      ewb_cyc_i = 1'b0;
      erg_stb_i = 1'b0;
      lwb_cyc_i = 1'b0;
      lrg_stb_i = 1'b0;
      if (!(e_done && i_done)) begin
         $display("contended read did not finish on both buses within 20 cycles");
         n_err++;
      end else begin
         check_val("ewb_dat_o", o.exp, e_dat);
         check_val("lwb_dat_o", o.exp2, i_dat);
         n_chk++;
         assert (ext_first) else begin
            $display("host bus did not finish before the firmware bus");
            n_err++;
         end
      end
   endtask

   //**************************************************
   // stimulus
   initial begin
      op_t         o;
      logic [15:0] r [5];
      logic [15:0] rd;
      int          edges;
      void'($urandom(29));                     // fixed seed
      comb_res  = 1'b1;
      lwb_adr_i = '0;
      lwb_dat_i = '0;
      lwb_cyc_i = 1'b0;
      lwb_we_i  = 1'b0;
      lwb_sel_i = '0;
      lrg_stb_i = 1'b0;
      ewb_adr_i = '0;
      ewb_dat_i = '0;
      ewb_cyc_i = 1'b0;
      ewb_we_i  = 1'b0;
      ewb_sel_i = '0;
      erg_stb_i = 1'b0;
      s3_i      = 1'b0;                        // switches give ms=1 os=1
      s4_i      = 1'b1;
      carrier_i = 1'b1;
      link_i    = 1'b1;
      iack_i    = 1'b0;
      for (int i = 0; i < 5; i++)
         r[i] = 16'($urandom());               // list address data

      // reset values
      add_op(K_EXT, 0, `DQ_VAR, 2'b11, 0, 16'hFC00, 1);
      add_op(K_EXT, 0, `DQ_CSR, 2'b11, 0, 16'h1030, 1);      // ok rl xl
      for (int i = 0; i < 6; i++)
         add_op(K_EXT, 0, 3'(i), 2'b11, 0, {8'hFF, ROM[8*i +: 8]}, 1);
      add_op(K_EXT, 1, `DQ_CSR, 2'b11, 16'h0100, 0, 0);      // il on, ca shows
      add_op(K_EXT, 0, `DQ_CSR, 2'b11, 0, 16'h3130, 1);
      add_op(K_EXT, 1, `DQ_CSR, 2'b11, 16'h0300, 0, 0);      // el on, checksum
      add_op(K_EXT, 0, 3'd0, 2'b11, 0, {8'hFF, ROM[55:48]}, 1);
      add_op(K_EXT, 0, 3'd1, 2'b11, 0, {8'hFF, ROM[63:56]}, 1);
      add_op(K_EXT, 0, 3'd2, 2'b11, 0, {8'hFF, ROM[23:16]}, 1);
      add_op(K_EXT, 1, `DQ_CSR, 2'b11, 16'h0100, 0, 0);      // el off
      add_op(K_EXT, 0, 3'd0, 2'b11, 0, {8'hFF, ROM[7:0]}, 1);
      // descriptor lists
      add_op(K_EXT, 1, `DQ_RDL_LO, 2'b11, r[0], 0, 0);
      add_op(K_EXT, 1, `DQ_RDL_HI, 2'b01, r[1], 0, 0);       // low byte only
      add_op(K_INT, 0, `DQ_RDL_LO, 2'b11, 0, r[0] & 16'hFFFE, 1);
      add_op(K_INT, 0, `DQ_RDL_HI, 2'b11, 0, r[1] & 16'h003F, 1);
      add_op(K_EXT, 0, `DQ_CSR, 2'b11, 0, 16'h3130, 1);
      add_op(K_EXT, 1, `DQ_RDL_HI, 2'b10, 16'hFF00, 0, 0);   // clears rl
      add_op(K_EXT, 0, `DQ_CSR, 2'b11, 0, 16'h3110, 1);
      add_op(K_INT, 0, `DQ_RDL_HI, 2'b11, 0, r[1] & 16'h003F, 1);
      add_op(K_EXT, 1, `DQ_TDL_LO, 2'b11, r[2], 0, 0);
      add_op(K_EXT, 1, `DQ_TDL_HI, 2'b11, r[3], 0, 0);       // clears xl
      add_op(K_INT, 0, `DQ_TDL_LO, 2'b11, 0, r[2] & 16'hFFFE, 1);
      add_op(K_INT, 0, `DQ_TDL_HI, 2'b11, 0, r[3] & 16'h003F, 1);
      add_op(K_INT, 0, `DQ_CSR, 2'b11, 0, 16'h3100, 1);
      // bus block
      add_op(K_INT, 1, 3'd0, 2'b01, 16'h0001, 0, 0);         // blkreg on
      add_op(K_INT, 0, 3'd0, 2'b11, 0, 16'h0001, 1);
      add_op(K_EXT, 1, `DQ_RDL_LO, 2'b11, r[4], 0, 0);
      add_op(K_EXT, 1, `DQ_CSR, 2'b11, 16'h0341, 0, 0);
      add_op(K_INT, 0, `DQ_RDL_LO, 2'b11, 0, r[0] & 16'hFFFE, 1);
      add_op(K_EXT, 0, `DQ_CSR, 2'b11, 0, 16'h3100, 1);
      add_op(K_EXT, 1, `DQ_VAR, 2'b11, 16'h8155, 0, 0);      // ms=1 rs=0 vec 55 id
      add_op(K_EXT, 0, `DQ_VAR, 2'b11, 0, 16'hDD55, 1);
      add_op(K_INT, 1, 3'd0, 2'b01, 16'h0000, 0, 0);         // blkreg off
      add_op(K_EXT, 1, `DQ_RDL_LO, 2'b11, r[4], 0, 0);
      add_op(K_INT, 0, `DQ_RDL_LO, 2'b11, 0, r[4] & 16'hFFFE, 1);
      add_op(K_EXT, 1, `DQ_CSR, 2'b11, 16'h0140, 0, 0);      // ie on
      add_op(K_EXT, 0, `DQ_CSR, 2'b11, 0, 16'h3140, 1);
      // interrupt
      add_op(K_INT, 1, `DQ_CSR, 2'b01, 16'h0080, 0, 0);      // set xi
      add_op(K_IRQ, 0, 0, 0, 0, 16'h0001, 1);
      add_op(K_EXT, 0, `DQ_CSR, 2'b11, 0, 16'h31C0, 1);
      add_op(K_IACK, 0, 0, 0, 0, 0, 0);
      add_op(K_IRQ, 0, 0, 0, 0, 16'h0000, 1);
      add_op(K_EXT, 1, `DQ_CSR, 2'b11, 16'h01C0, 0, 0);      // bit 7 clears xi
      add_op(K_EXT, 0, `DQ_CSR, 2'b11, 0, 16'h3140, 1);
      add_op(K_INT, 1, `DQ_CSR, 2'b01, 16'h0080, 0, 0);      // xi again
      add_op(K_IRQ, 0, 0, 0, 0, 16'h0001, 1);
      add_op(K_EXT, 1, `DQ_CSR, 2'b11, 16'h0180, 0, 0);      // ie off and xi cleared
      add_op(K_IRQ, 0, 0, 0, 0, 16'h0000, 1);
      add_op(K_EXT, 0, `DQ_CSR, 2'b11, 0, 16'h3100, 1);
      add_op(K_INT, 1, `DQ_CSR, 2'b01, 16'h0080, 0, 0);
      add_op(K_IRQ, 0, 0, 0, 0, 16'h0000, 1);
      // contended read, VAR on host and CSR on firmware
      o = '{K_DUAL, 1'b0, `DQ_VAR, 2'b11, 16'h0, 16'hDD55, 1'b1, `DQ_CSR, 16'h3180};
      ops.push_back(o);

      repeat (4) @(posedge lwb_clk_i);
      @(negedge lwb_clk_i);
      comb_res = 1'b0;
      idle_cycles(2);

      foreach (ops[k]) begin
         o = ops[k];
         case (o.kind)
            K_EXT, K_INT: begin
               bus_op(o, rd, edges);
               if (o.chk)
                  check_val((o.kind == K_EXT) ? "ewb_dat_o" : "lwb_dat_o", o.exp, rd);
               check_val((o.kind == K_EXT) ? "ewb_ack_o delay" : "lwb_ack_o delay", 3, edges);
            end
            K_IRQ:  check_irq(o.exp[0]);
            K_IACK: begin
               iack_i = 1'b1;
               @(posedge lwb_clk_i);
               @(negedge lwb_clk_i);
               iack_i = 1'b0;
            end
            K_DUAL: dual_read(o);
            default: ;
         endcase
         idle_cycles(2);                       // lets the grant clear
      end

      $display("checks %0d, errors %0d, assertion errors %0d",
               n_chk, n_err, i_dut.i_chk.err_cnt);
      if (n_err == 0 && i_dut.i_chk.err_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dq_regs_checker.sv */
//**************************************************
// protocol assertions, bound into the top level
// ack only inside a granted cycle, one grant at a
// time, fixed ack delay from idle, irq off without ie
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module dq_regs_checker (
   input logic       lwb_clk_i,
   input logic       comb_res,
   input logic       ewb_cyc_i,
   input logic       erg_stb_i,
   input logic       ewb_ack_i,
   input logic       lwb_cyc_i,
   input logic       lrg_stb_i,
   input logic       lwb_ack_i,
   input logic [1:0] gnt_i,         // arbiter grants, host in bit 0
   input logic       ie_i,
   input logic       irq_i
);

   int   err_cnt = 0;               // failed assertions
   logic ext_req;
   logic int_req;

   assign ext_req = ewb_cyc_i & erg_stb_i;
   assign int_req = lwb_cyc_i & lrg_stb_i;

   // ack checked mid cycle, while the master still holds it
   ack_in_cycle: assert property (@(negedge lwb_clk_i) disable iff (comb_res)
      (!ewb_ack_i || (ext_req && gnt_i[0])) && (!lwb_ack_i || (int_req && gnt_i[1])))
   else begin
      err_cnt++;
      $error("ack outside of its granted bus cycle");
   end

   one_grant: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
      !(gnt_i[0] && gnt_i[1]))
   else begin
      err_cnt++;
      $error("both buses granted");
   end

   // idle block, ack after the third edge, master drops the cycle on ack
   ext_delay: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
      ext_req && gnt_i == 2'b00 |=>
         (ext_req && !ewb_ack_i) [*2] ##1 (ewb_ack_i || !ext_req))
   else begin
      err_cnt++;
      $error("host ack delay from idle is not 3 edges");
   end

   int_delay: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
      int_req && !ext_req && gnt_i == 2'b00 |=>
         (int_req && !lwb_ack_i) [*2] ##1 (lwb_ack_i || !int_req))
   else begin
      err_cnt++;
      $error("firmware ack delay from idle is not 3 edges");
   end

   irq_off: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
      !ie_i |=> !irq_i)
   else begin
      err_cnt++;
      $error("irq_o high after ie was low");
   end

endmodule

bind dq_regs_top dq_regs_checker i_chk (
   .lwb_clk_i (lwb_clk_i),
   .comb_res  (comb_res),
   .ewb_cyc_i (ewb_cyc_i),
   .erg_stb_i (erg_stb_i),
   .ewb_ack_i (ewb_ack_o),
   .lwb_cyc_i (lwb_cyc_i),
   .lrg_stb_i (lrg_stb_i),
   .lwb_ack_i (lwb_ack_o),
   .gnt_i     (i_arb.gnt),
   .ie_i      (csr_ie),
   .irq_i     (irq_o)
);

`default_nettype wire

/* dq_regs_top.sv */
//**************************************************
// register block of the Ethernet controller
// host bus (ewb) and firmware bus (lwb) on plain
// pins, one bus port each into arbiter and regfile
//**************************************************
`timescale 1ns/1ps
`include "dq_defs.svh"
`default_nettype none

module dq_regs_top (
   input  logic                 lwb_clk_i,
   input  logic                 comb_res,
   // firmware bus
   input  logic [`DQ_ADR_W-1:0] lwb_adr_i,
   input  logic [`DQ_DAT_W-1:0] lwb_dat_i,
   input  logic                 lwb_cyc_i,
   input  logic                 lwb_we_i,
   input  logic [`DQ_SEL_W-1:0] lwb_sel_i,
   input  logic                 lrg_stb_i,
   output logic [`DQ_DAT_W-1:0] lwb_dat_o,
   output logic                 lwb_ack_o,
   // host bus
   input  logic [`DQ_ADR_W-1:0] ewb_adr_i,
   input  logic [`DQ_DAT_W-1:0] ewb_dat_i,
   input  logic                 ewb_cyc_i,
   input  logic                 ewb_we_i,
   input  logic [`DQ_SEL_W-1:0] ewb_sel_i,
   input  logic                 erg_stb_i,
   output logic [`DQ_DAT_W-1:0] ewb_dat_o,
   output logic                 ewb_ack_o,
   // switches, line status, interrupt
   input  logic                 s3_i,
   input  logic                 s4_i,
   input  logic                 carrier_i,
   input  logic                 link_i,
   input  logic                 iack_i,
   output logic                 irq_o
);

   logic csr_ri;
   logic csr_xi;
   logic csr_ie;

   dq_port_if ext_port ();
   dq_port_if int_port ();

   // pins into the ports
   assign ext_port.cyc  = ewb_cyc_i;
   assign ext_port.stb  = erg_stb_i;
   assign ext_port.we   = ewb_we_i;
   assign ext_port.adr  = ewb_adr_i;
   assign ext_port.sel  = ewb_sel_i;
   assign ext_port.wdat = ewb_dat_i;
   assign int_port.cyc  = lwb_cyc_i;
   assign int_port.stb  = lrg_stb_i;
   assign int_port.we   = lwb_we_i;
   assign int_port.adr  = lwb_adr_i;
   assign int_port.sel  = lwb_sel_i;
   assign int_port.wdat = lwb_dat_i;

   assign ewb_ack_o = ext_port.ack;
   assign ewb_dat_o = ext_port.rdat;
   assign lwb_ack_o = int_port.ack;
   assign lwb_dat_o = int_port.rdat;

   dq_bus_arbiter i_arb (
      .lwb_clk_i (lwb_clk_i),
      .comb_res  (comb_res),
      .ext_p     (ext_port.arb),
      .int_p     (int_port.arb)
   );

   dq_regfile i_regs (
      .lwb_clk_i (lwb_clk_i),
      .comb_res  (comb_res),
      .ext_p     (ext_port.regs),
      .int_p     (int_port.regs),
      .s3_i      (s3_i),
      .s4_i      (s4_i),
      .carrier_i (carrier_i),
      .link_i    (link_i),
      .csr_ri_o  (csr_ri),
      .csr_xi_o  (csr_xi),
      .csr_ie_o  (csr_ie)
   );

   dq_irq_ctrl i_irq (
      .lwb_clk_i (lwb_clk_i),
      .comb_res  (comb_res),
      .ri_i      (csr_ri),
      .xi_i      (csr_xi),
      .ie_i      (csr_ie),
      .iack_i    (iack_i),
      .irq_o     (irq_o)
   );

endmodule

`default_nettype wire

/* dq_regfile.sv */
//**************************************************
// CSR, VAR, descriptor list addresses and blkreg
// host bus writes are gated by blkreg except VAR,
// firmware writes win on a collision
// read data is registered on each read strobe
//**************************************************
`timescale 1ns/1ps
`include "dq_defs.svh"
`default_nettype none

module dq_regfile
   import dq_pkg::*;
(
   input  logic     lwb_clk_i,
   input  logic     comb_res,
   dq_port_if.regs  ext_p,        // host bus
   dq_port_if.regs  int_p,        // firmware bus
   input  logic     s3_i,         // mode switch
   input  logic     s4_i,         // option switch
   input  logic     carrier_i,
   input  logic     link_i,
   output logic     csr_ri_o,
   output logic     csr_xi_o,
   output logic     csr_ie_o
);

   localparam logic [63:0] SA_ROM = `DQ_SA_ROM;

   dq_csr_t      csr_q;           // stored CSR bits
   dq_csr_t      csr_rd;          // CSR as read
   dq_var_t      var_q;
   logic         blkreg;          // firmware blocks host writes
   logic         allow;           // host writes enabled
   logic [15:1]  rbdl_lo;
   logic [5:0]   rbdl_hi;
   logic [15:1]  tbdl_lo;
   logic [5:0]   tbdl_hi;
   logic         chk_mode;        // checksum readout
   logic [2:0]   rom_sel;         // rom byte index
   dq_reg_e      ext_adr;
   dq_reg_e      int_adr;

   assign ext_adr = dq_reg_e'(ext_p.adr);
   assign int_adr = dq_reg_e'(int_p.adr);
   assign allow   = ~blkreg;

   always_comb begin
      csr_rd    = csr_q;
      csr_rd.ca = csr_q.il & carrier_i;  // no carrier in int loopback
      csr_rd.ok = link_i;
   end

   //**************************************************
   // control registers
   always_ff @(posedge lwb_clk_i or posedge comb_res) begin
      if (comb_res) begin
         csr_q      <= '0;
         csr_q.rl   <= 1'b1;                // lists start invalid
         csr_q.xl   <= 1'b1;
         var_q      <= '0;
         var_q.ms   <= ~s3_i;
         var_q.os   <= s4_i & ~s3_i;
         var_q.rs   <= ~s3_i;               // self test after reset
         var_q.s3   <= ~s3_i;
         var_q.s2   <= ~s3_i;
         var_q.s1   <= ~s3_i;
         blkreg     <= 1'b0;
      end else begin
         // host bus
         if (ext_p.wr_req) begin
            case (ext_adr)
               DQ_R_RDL_HI: if (allow && ext_p.sel[1]) csr_q.rl <= 1'b0;
               DQ_R_TDL_HI: if (allow && ext_p.sel[1]) csr_q.xl <= 1'b0;
               DQ_R_VAR: begin                // never blocked
                  if (ext_p.sel[0]) begin
                     var_q.id       <= ext_p.wdat[0];
                     var_q.vec[5:0] <= ext_p.wdat[7:2];
                  end
                  if (ext_p.sel[1]) begin
                     var_q.vec[7:6] <= ext_p.wdat[9:8];
                     var_q.ms       <= ext_p.wdat[15];
                     if (!ext_p.wdat[15])
                        {var_q.os, var_q.rs, var_q.s3, var_q.s2, var_q.s1} <= 5'b0;
                     else
                        var_q.rs <= ext_p.wdat[13];
                  end
               end
               DQ_R_CSR: if (allow) begin
                  if (ext_p.sel[0]) begin
                     csr_q.ie <= ext_p.wdat[6];
                     csr_q.bd <= ext_p.wdat[3];
                     csr_q.re <= ext_p.wdat[0];
                     if (ext_p.wdat[7]) begin  // write 1 to clear
                        csr_q.xi <= 1'b0;
                        csr_q.ni <= 1'b0;
                     end
                  end
                  if (ext_p.sel[1]) begin
                     csr_q.il <= ext_p.wdat[8];
                     csr_q.el <= ext_p.wdat[9];
                     csr_q.se <= ext_p.wdat[10];
                     if (ext_p.wdat[15])
                        csr_q.ri <= 1'b0;
                  end
               end
               default: ;
            endcase
         end
         // firmware bus, last so it wins
         if (int_p.wr_req) begin
            case (int_adr)
               DQ_R_SA0: if (int_p.sel[0]) blkreg <= int_p.wdat[0];
               DQ_R_VAR: if (int_p.sel[1]) begin
                  {var_q.rs, var_q.s3, var_q.s2, var_q.s1} <= int_p.wdat[13:10];
               end
               DQ_R_CSR: begin
                  if (int_p.sel[0]) begin
                     csr_q.ni <= int_p.wdat[2];
                     csr_q.xl <= int_p.wdat[4];
                     csr_q.rl <= int_p.wdat[5];
                     csr_q.xi <= int_p.wdat[7];
                  end
                  if (int_p.sel[1])
                     csr_q.ri <= int_p.wdat[15];
               end
               default: ;
            endcase
         end
      end
   end

   //**************************************************
   // descriptor list addresses, host writes only
   always_ff @(posedge lwb_clk_i) begin
      if (ext_p.wr_req && allow) begin
         case (ext_adr)
            DQ_R_RDL_LO: begin
               if (ext_p.sel[0]) rbdl_lo[7:1]  <= ext_p.wdat[7:1];  // word aligned
               if (ext_p.sel[1]) rbdl_lo[15:8] <= ext_p.wdat[15:8];
            end
            DQ_R_RDL_HI: if (ext_p.sel[0]) rbdl_hi <= ext_p.wdat[5:0];
            DQ_R_TDL_LO: begin
               if (ext_p.sel[0]) tbdl_lo[7:1]  <= ext_p.wdat[7:1];
               if (ext_p.sel[1]) tbdl_lo[15:8] <= ext_p.wdat[15:8];
            end
            DQ_R_TDL_HI: if (ext_p.sel[0]) tbdl_hi <= ext_p.wdat[5:0];
            default: ;
         endcase
      end
   end

   //**************************************************
   // read data
   assign chk_mode = csr_q.el & ~csr_q.bd & ~csr_q.re;
   assign rom_sel  = (chk_mode && ext_p.adr[2:1] == 2'b00) ? ext_p.adr + 3'd6 : ext_p.adr;

   always_ff @(posedge lwb_clk_i) begin
      if (ext_p.rd_req) begin
         case (ext_adr)
            DQ_R_VAR: ext_p.rdat <= var_q;
            DQ_R_CSR: ext_p.rdat <= csr_rd;
            default:  ext_p.rdat <= {8'hFF, SA_ROM[{rom_sel, 3'b000} +: 8]};  // sa rom
         endcase
      end
   end

   always_ff @(posedge lwb_clk_i) begin
      if (int_p.rd_req) begin
         case (int_adr)
            DQ_R_SA0:    int_p.rdat <= {15'b0, blkreg};
            DQ_R_RDL_LO: int_p.rdat <= {rbdl_lo, 1'b0};
            DQ_R_RDL_HI: int_p.rdat <= {10'b0, rbdl_hi};
            DQ_R_TDL_LO: int_p.rdat <= {tbdl_lo, 1'b0};
            DQ_R_TDL_HI: int_p.rdat <= {10'b0, tbdl_hi};
            DQ_R_VAR:    int_p.rdat <= var_q;
            DQ_R_CSR:    int_p.rdat <= csr_rd;
            default: ;                        // offset 1 keeps old data
         endcase
      end
   end

   assign csr_ri_o = csr_q.ri;
   assign csr_xi_o = csr_q.xi;
   assign csr_ie_o = csr_q.ie;

endmodule

`default_nettype wire

/* dq_irq_ctrl.sv */
//**************************************************
// host interrupt request
// set on a rising ri or xi while ie is on, held
// until iack_i or until ie goes off
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module dq_irq_ctrl (
   input  logic lwb_clk_i,
   input  logic comb_res,
   input  logic ri_i,        // receive request
   input  logic xi_i,        // transmit request
   input  logic ie_i,        // interrupt enable
   input  logic iack_i,      // host acknowledge
   output logic irq_o
);

   logic req;                // combined request
   logic req_d;              // delayed copy
   logic rise_q;             // rising edge seen with ie on
   logic pend;

   assign req = ri_i | xi_i;

   always_ff @(posedge lwb_clk_i or posedge comb_res) begin
      if (comb_res) begin
         req_d  <= 1'b0;
         rise_q <= 1'b0;
         pend   <= 1'b0;
      end else begin
         req_d  <= req;
         rise_q <= req & ~req_d & ie_i;
         if (!ie_i || iack_i)
            pend <= 1'b0;         // disable or ack drops it
         else if (rise_q)
            pend <= 1'b1;
      end
   end

   assign irq_o = pend;

endmodule

`default_nettype wire

/* dq_bus_arbiter.sv */
//**************************************************
// grants the register block to one bus at a time
// host bus wins a tie; ack comes after the shift
// chain fills and drops as soon as the cycle ends
//**************************************************
`timescale 1ns/1ps
`include "dq_defs.svh"
`default_nettype none

module dq_bus_arbiter (
   input  logic     lwb_clk_i,
   input  logic     comb_res,
   dq_port_if.arb   ext_p,      // host bus
   dq_port_if.arb   int_p       // firmware bus
);

   // index 0 is the host bus, index 1 the firmware bus
   logic [1:0]                 req;        // cyc & stb
   logic [1:0]                 cyc;
   logic [1:0]                 we;
   logic [1:0]                 gnt;        // grant flags
   logic [1:0]                 ack;
   logic [1:0]                 stb_q;      // qualified strobe
   logic [`DQ_ACK_STAGES-1:0]  ack_sr [2]; // ack delay chains

   assign cyc = {int_p.cyc, ext_p.cyc};
   assign req = {int_p.cyc & int_p.stb, ext_p.cyc & ext_p.stb};
   assign we  = {int_p.we, ext_p.we};

   //**************************************************
   // grant, held until cyc drops
   always_ff @(posedge lwb_clk_i or posedge comb_res) begin
      if (comb_res) begin
         gnt <= 2'b00;
      end else begin
         for (int i = 0; i < 2; i++) begin
            if (gnt[i] && !cyc[i])
               gnt[i] <= 1'b0;            // release after cycle
         end
         if (gnt == 2'b00) begin
            if (req[0])
               gnt[0] <= 1'b1;            // host has priority
            else if (req[1])
               gnt[1] <= 1'b1;
         end
      end
   end

   // ack chains, held clear while not granted
   always_ff @(posedge lwb_clk_i or posedge comb_res) begin
      if (comb_res) begin
         ack_sr[0] <= '0;
         ack_sr[1] <= '0;
      end else begin
         for (int i = 0; i < 2; i++) begin
            if (!gnt[i])
               ack_sr[i] <= '0;
            else
               ack_sr[i] <= {ack_sr[i][`DQ_ACK_STAGES-2:0], req[i]};
         end
      end
   end

   assign ack[0]   = req[0] & ack_sr[0][`DQ_ACK_STAGES-1];
   assign ack[1]   = req[1] & ack_sr[1][`DQ_ACK_STAGES-1];
   assign stb_q    = gnt & req & ~ack;     // active until ack

   assign ext_p.ack    = ack[0];
   assign ext_p.rd_req = stb_q[0] & ~we[0];
   assign ext_p.wr_req = stb_q[0] & we[0];
   assign int_p.ack    = ack[1];
   assign int_p.rd_req = stb_q[1] & ~we[1];
   assign int_p.wr_req = stb_q[1] & we[1];

endmodule

`default_nettype wire

/* dq_port_if.sv */
//**************************************************
// one bus port of the register block
// pins from the top, strobes and ack from the
// arbiter, read data from the register file
//**************************************************
`timescale 1ns/1ps
`include "dq_defs.svh"
`default_nettype none

interface dq_port_if;

   logic                  cyc;      // bus cycle
   logic                  stb;      // register strobe
   logic                  we;       // 1 = write
   logic [`DQ_ADR_W-1:0]  adr;      // word offset
   logic [`DQ_SEL_W-1:0]  sel;      // byte lanes
   logic [`DQ_DAT_W-1:0]  wdat;     // write data
   logic [`DQ_DAT_W-1:0]  rdat;     // read data, valid with ack

   logic                  ack;      // cycle done
   logic                  rd_req;   // read strobe to regfile
   logic                  wr_req;   // write strobe to regfile

   modport arb (
      input  cyc,
      input  stb,
      input  we,
      output ack,
      output rd_req,
      output wr_req
   );

   modport regs (
      input  rd_req,
      input  wr_req,
      input  adr,
      input  sel,
      input  wdat,
      output rdat
   );

endinterface

`default_nettype wire

/* dq_pkg.sv */
//**************************************************
// register layouts of the controller
// CSR and VAR bit structs plus the offset enum used
// by the register file decode
//**************************************************
`include "dq_defs.svh"
`default_nettype none

package dq_pkg;

   // control/status register, bit 15 first
   typedef struct packed {
      logic ri;         // receive interrupt request
      logic rsv14;      // always 0
      logic ca;         // carrier, 0 in internal loopback
      logic ok;         // link ok
      logic rsv11;      // always 0
      logic se;         // sanity timer enable
      logic el;         // external loopback
      logic il;         // internal loopback, active low
      logic xi;         // transmit interrupt request
      logic ie;         // interrupt enable
      logic rl;         // receive list invalid
      logic xl;         // transmit list invalid
      logic bd;         // boot/diag rom load
      logic ni;         // nxm interrupt
      logic sr;         // soft reset, reads 0
      logic re;         // receiver enable
   } dq_csr_t;

   // vector address register
   typedef struct packed {
      logic       ms;   // mode select
      logic       os;   // option switch
      logic       rs;   // request self test
      logic       s3;   // self test status
      logic       s2;
      logic       s1;
      logic [7:0] vec;  // interrupt vector
      logic       rsv1; // always 0
      logic       id;   // identity test bit
   } dq_var_t;

   typedef enum logic [2:0] {
      DQ_R_SA0    = 3'd0,        // rom byte 0, blkreg on firmware bus
      DQ_R_SA1    = 3'd1,        // rom byte 1
      DQ_R_RDL_LO = `DQ_RDL_LO,
      DQ_R_RDL_HI = `DQ_RDL_HI,
      DQ_R_TDL_LO = `DQ_TDL_LO,
      DQ_R_TDL_HI = `DQ_TDL_HI,
      DQ_R_VAR    = `DQ_VAR,
      DQ_R_CSR    = `DQ_CSR
   } dq_reg_e;

endpackage

`default_nettype wire

/* dq_defs.svh */
//**************************************************
// shared widths, register offsets, station address
// ROM contents and bus ack delay of the register block
// include wherever these values are needed
//**************************************************
`ifndef DQ_DEFS_SVH
`define DQ_DEFS_SVH

`default_nettype none

// bus geometry
`define DQ_DAT_W       16        // data bus width
`define DQ_ADR_W       3         // word address width
`define DQ_SEL_W       2         // byte selects

`define DQ_ACK_STAGES  2         // ack shift chain length

// station address bytes 0..5, checksum in bytes 6..7, byte 0 lowest
`define DQ_SA_ROM      64'hC3A5_6F5E_4D3C_1A02

// register word offsets
`define DQ_RDL_LO      3'd2      // receive list low
`define DQ_RDL_HI      3'd3      // receive list high
`define DQ_TDL_LO      3'd4      // transmit list low
`define DQ_TDL_HI      3'd5      // transmit list high
`define DQ_VAR         3'd6      // vector address reg
`define DQ_CSR         3'd7      // control/status reg

`default_nettype wire

`endif
